//--- frame_overlay.f
+incdir+logic
logic/frame_overlay_pkg.sv
logic/layer_match_stage.sv
logic/color_priority_stage.sv
logic/frame_overlay_top.sv
dv/frame_overlay_checker.sv
dv/frame_overlay_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the frame overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert \
	-f frame_overlay.f \
	--top-module frame_overlay_tb \
	-o frame_overlay_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/frame_overlay_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$sim_log"; then
	exit 1
fi
exit 0

//--- dv/frame_overlay_tb.sv
`default_nettype none

module frame_overlay_tb
	import frame_overlay_pkg::*;
();

	// same layout tables the DUT gets
	`include "frame_layout.svh"

	localparam int reset_timeout = 20;
	localparam int random_count  = 2000;

	logic   clk = 1'b0;
	logic   reset;
	coord_t pix_x;
	coord_t pix_y;
	logic   video_on;
	rgb_t   rgb;

	// expectations of the two pixels still in flight, [1] is the older one
	rgb_t  exp_q   [0:1];
	string name_q  [0:1];
	bit    valid_q [0:1];

	logic [31:0] rng_state     = 32'h0c53_ca27;
	bit          reset_at_edge = 1'b1;
	int          checks        = 0;
	int          mismatches    = 0;
	int          timeouts      = 0;

	frame_overlay_top dut (
		.clk      (clk),
		.reset    (reset),
		.pix_x    (pix_x),
		.pix_y    (pix_y),
		.video_on (video_on),
		.rgb      (rgb)
	);

	always #50 clk = ~clk;

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#10;
		reset = 1'b0;
	end

	// --------------------
	// reference model
	// --------------------

	// on the ring when inside the box and closer than thickness to some edge
	function automatic bit on_frame(input frame_t f, input int x, input int y);
		int left;
		int right;
		int top;
		int bottom;
		int nearest;
		left   = x - int'(f.x_left);
		right  = int'(f.x_right) - x;
		top    = y - int'(f.y_top);
		bottom = int'(f.y_bottom) - y;
		if (left < 0 || right < 0 || top < 0 || bottom < 0) begin
			return 1'b0;
		end
		nearest = left;
		if (right < nearest) begin
			nearest = right;
		end
		if (top < nearest) begin
			nearest = top;
		end
		if (bottom < nearest) begin
			nearest = bottom;
		end
		return nearest < int'(f.thickness);
	endfunction

	function automatic rgb_t expected_color(input int x, input int y, input bit von);
		bit panel;
		bit digit;
		bit border;
		panel  = 1'b0;
		digit  = 1'b0;
		border = 1'b0;
		for (int i = 0; i < panel_count; i++) begin
			panel |= on_frame(panel_frames[i], x, y);
		end
		for (int i = 0; i < digit_count; i++) begin
			digit |= on_frame(digit_frames[i], x, y);
		end
		for (int i = 0; i < border_count; i++) begin
			border |= on_frame(border_frames[i], x, y);
		end
		if (!von) begin
			return blank_color;
		end else if (panel) begin
			return panel_color;
		end else if (digit) begin
			return digit_color;
		end else if (border) begin
			return border_color;
		end
		return blank_color;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s;
		r = r ^ (r << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// --------------------
	// stimulus
	// --------------------

	// one pixel per clock; checks the pixel driven two clocks earlier
	task automatic apply_pixel(input int x, input int y, input bit von, input string name);
		@(posedge clk);
		reset_at_edge = reset;
		#10;
		if (valid_q[1]) begin
			checks++;
			assert (rgb == exp_q[1]) else begin
				mismatches++;
				$display("mismatch %s: expected %h, actual %h", name_q[1], exp_q[1], rgb);
			end
		end
		exp_q[1]   = exp_q[0];
		name_q[1]  = name_q[0];
		valid_q[1] = valid_q[0];
		exp_q[0]   = expected_color(x, y, von);
		name_q[0]  = name;
		valid_q[0] = 1'b1;
		pix_x      = coord_t'(x);
		pix_y      = coord_t'(y);
		video_on   = von;
	endtask

	// idle pixels until the DUT has seen reset low
	task automatic wait_reset_release(output bit released);
		int cycles;
		cycles = 0;
		while (reset_at_edge && cycles < reset_timeout) begin
			apply_pixel(0, 0, 1'b0, "reset");
			cycles++;
		end
		released = !reset_at_edge;
	endtask

	// all four edges, then the last ring column and the first pixel inside
	task automatic sweep_frame(input frame_t f, input string name);
		int xm;
		int ym;
		int t;
		xm = (int'(f.x_left) + int'(f.x_right)) / 2;
		ym = (int'(f.y_top) + int'(f.y_bottom)) / 2;
		t  = int'(f.thickness);
		apply_pixel(int'(f.x_left), ym, 1'b1, name);
		apply_pixel(int'(f.x_right), ym, 1'b1, name);
		apply_pixel(xm, int'(f.y_top), 1'b1, name);
		apply_pixel(xm, int'(f.y_bottom), 1'b1, name);
		apply_pixel(int'(f.x_left) + t - 1, ym, 1'b1, name);
		apply_pixel(int'(f.x_left) + t, ym, 1'b1, {name, "_inner"});
	endtask

	task automatic run_tests();
		int x;
		int y;
		bit von;
		// frame pixels while blanked
		apply_pixel(169, 100, 1'b0, "blanking");
		apply_pixel(307, 320, 1'b0, "blanking");
		apply_pixel(28, 100, 1'b0, "blanking");
		// spot pixels
		apply_pixel(169, 100, 1'b1, "panel_edge");
		apply_pixel(530, 100, 1'b1, "panel_edge");
		apply_pixel(174, 100, 1'b1, "panel_inner");
		apply_pixel(307, 320, 1'b1, "digit_shared");
		apply_pixel(28, 100, 1'b1, "border_edge");
		apply_pixel(300, 419, 1'b1, "border_edge");
		apply_pixel(600, 450, 1'b1, "outside");
		for (int i = 0; i < panel_count; i++) begin
			sweep_frame(panel_frames[i], "panel_sweep");
		end
		for (int i = 0; i < digit_count; i++) begin
			sweep_frame(digit_frames[i], "digit_sweep");
		end
		for (int i = 0; i < border_count; i++) begin
			sweep_frame(border_frames[i], "border_sweep");
		end
		// back-to-back random raster positions, about 90% active
		for (int n = 0; n < random_count; n++) begin
			rng_state = xorshift(rng_state);
			x = int'(rng_state % screen_width);
			rng_state = xorshift(rng_state);
			y = int'(rng_state % screen_height);
			rng_state = xorshift(rng_state);
			von = (rng_state % 10) != 0;
			apply_pixel(x, y, von, "random");
		end
		// flush the two pixels still in flight
		apply_pixel(0, 0, 1'b0, "drain");
		apply_pixel(0, 0, 1'b0, "drain");
	endtask

	task automatic finish_run();
		int assertion_failures;
		assertion_failures = dut.u_checker.failures;
		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checks, mismatches, timeouts, assertion_failures);
		if (mismatches == 0 && timeouts == 0 && assertion_failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	initial begin
		bit released;
		pix_x    = '0;
		pix_y    = '0;
		video_on = 1'b0;
		wait_reset_release(released);
		if (!released) begin
			timeouts++;
			$display("timeout: reset still high after %0d cycles", reset_timeout);
		end else begin
			run_tests();
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- dv/frame_overlay_checker.sv
`default_nettype none

module frame_overlay_checker
	import frame_overlay_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic video_on,
	input rgb_t rgb
);

	// count of failed assertions
	int failures = 0;

	// --------------------
	// reset
	// --------------------

	// cleared output register, then the cleared hits register drains through
	a_reset_black: assert property (
		@(posedge clk) ($past(reset) || $past(reset, 2)) |-> (rgb == blank_color)
	) else begin
		failures++;
		$error("rgb not black during or right after reset");
	end

	// --------------------
	// output color
	// --------------------

	// blanking takes two stages to reach the output
	a_blanking_black: assert property (
		@(posedge clk) disable iff (reset)
		!$past(video_on, 2) |-> (rgb == blank_color)
	) else begin
		failures++;
		$error("rgb not black two cycles after video_on was low");
	end

	a_legal_color: assert property (
		@(posedge clk) disable iff (reset)
		(rgb == panel_color) || (rgb == digit_color) ||
		(rgb == border_color) || (rgb == blank_color)
	) else begin
		failures++;
		$error("rgb is not one of the layer colors");
	end

endmodule

bind frame_overlay_top frame_overlay_checker u_checker (
	.clk      (clk),
	.reset    (reset),
	.video_on (video_on),
	.rgb      (rgb)
);

`default_nettype wire

//--- logic/frame_overlay_top.sv
`default_nettype none

module frame_overlay_top
	import frame_overlay_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  coord_t pix_x,
	input  coord_t pix_y,
	input  logic   video_on,
	output rgb_t   rgb
);

	// frame tables and their counts
	`include "frame_layout.svh"

	pixel_beat_t pixel;
	layer_hits_t hits;

	// raster position from the sync generator
	always_comb begin
		pixel.video_on = video_on;
		pixel.x        = pix_x;
		pixel.y        = pix_y;
	end

	// --------------------
	// stage one
	// --------------------

	layer_match_stage #(
		.panel_count   (panel_count),
		.digit_count   (digit_count),
		.border_count  (border_count),
		.panel_frames  (panel_frames),
		.digit_frames  (digit_frames),
		.border_frames (border_frames)
	) u_layer_match (
		.clk   (clk),
		.reset (reset),
		.pixel (pixel),
		.hits  (hits)
	);

	// --------------------
	// stage two
	// --------------------

	color_priority_stage u_color_priority (
		.clk   (clk),
		.reset (reset),
		.hits  (hits),
		.rgb   (rgb)
	);

endmodule

`default_nettype wire

//--- logic/color_priority_stage.sv
`default_nettype none

module color_priority_stage
	import frame_overlay_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  layer_hits_t hits,
	output rgb_t        rgb
);

	rgb_t rgb_next;

	// --------------------
	// layer priority
	// --------------------

	// panel over digit over border, black when nothing is hit
	always_comb begin
		rgb_next = blank_color;
		if (hits.video_on) begin
			if (hits.panel_hit) begin
				rgb_next = panel_color;
			end else if (hits.digit_hit) begin
				rgb_next = digit_color;
			end else if (hits.border_hit) begin
				rgb_next = border_color;
			end
		end
	end

	// --------------------
	// output register
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			rgb <= blank_color;
		end else begin
			rgb <= rgb_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/layer_match_stage.sv
`default_nettype none

module layer_match_stage
	import frame_overlay_pkg::*;
#(
	parameter int panel_count  = 1,
	parameter int digit_count  = 1,
	parameter int border_count = 1,
	parameter frame_t [0:panel_count-1]  panel_frames  = '0,
	parameter frame_t [0:digit_count-1]  digit_frames  = '0,
	parameter frame_t [0:border_count-1] border_frames = '0
) (
	input  logic        clk,
	input  logic        reset,
	input  pixel_beat_t pixel,
	output layer_hits_t hits
);

	// --------------------
	// outline test
	// --------------------

	// true on the ring between the outer box and the box shrunk by the thickness
	function automatic logic outline_hit(
		input frame_t f,
		input coord_t x,
		input coord_t y
	);
		coord_t inner_left;
		coord_t inner_right;
		coord_t inner_top;
		coord_t inner_bottom;
		logic   in_outer;
		logic   in_inner;
		inner_left   = f.x_left   + coord_t'(f.thickness);
		inner_right  = f.x_right  - coord_t'(f.thickness);
		inner_top    = f.y_top    + coord_t'(f.thickness);
		inner_bottom = f.y_bottom - coord_t'(f.thickness);
		in_outer = (x >= f.x_left) && (x <= f.x_right) &&
			(y >= f.y_top) && (y <= f.y_bottom);
		in_inner = (x >= inner_left) && (x <= inner_right) &&
			(y >= inner_top) && (y <= inner_bottom);
		return in_outer && !in_inner;
	endfunction

	// --------------------
	// per-frame matches
	// --------------------

	logic [panel_count-1:0]  panel_match;
	logic [digit_count-1:0]  digit_match;
	logic [border_count-1:0] border_match;

	for (genvar i = 0; i < panel_count; i++) begin : g_panel
		assign panel_match[i] = outline_hit(panel_frames[i], pixel.x, pixel.y);
	end

	// neighbouring digit boxes may share a column, the OR absorbs it
	for (genvar i = 0; i < digit_count; i++) begin : g_digit
		assign digit_match[i] = outline_hit(digit_frames[i], pixel.x, pixel.y);
	end

	for (genvar i = 0; i < border_count; i++) begin : g_border
		assign border_match[i] = outline_hit(border_frames[i], pixel.x, pixel.y);
	end

	// --------------------
	// stage register
	// --------------------

	layer_hits_t hits_next;

	always_comb begin
		hits_next.video_on   = pixel.video_on;
		hits_next.panel_hit  = |panel_match;
		hits_next.digit_hit  = |digit_match;
		hits_next.border_hit = |border_match;
	end

	// video_on rides with the hits so blanking stays aligned
	always_ff @(posedge clk) begin
		if (reset) begin
			hits <= '0;
		end else begin
			hits <= hits_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/frame_overlay_pkg.sv
`default_nettype none

package frame_overlay_pkg;

	// --------------------
	// raster geometry
	// --------------------

	localparam int screen_width  = 640;
	localparam int screen_height = 480;

	// one pixel coordinate, wide enough for 640 columns
	typedef logic [9:0] coord_t;

	// frame line thickness in pixels
	typedef logic [3:0] thick_t;

	// 4 bits per channel, red in the top nibble
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	// outer bounds are inclusive, thickness eats inward from every side
	typedef struct packed {
		coord_t x_left;
		coord_t x_right;
		coord_t y_top;
		coord_t y_bottom;
		thick_t thickness;
	} frame_t;

	// one raster position as it leaves the sync generator
	typedef struct packed {
		logic   video_on;
		coord_t x;
		coord_t y;
	} pixel_beat_t;

	// stage one result, blanking travels alongside the hits
	typedef struct packed {
		logic video_on;
		logic panel_hit;
		logic digit_hit;
		logic border_hit;
	} layer_hits_t;

	// --------------------
	// layer colors
	// --------------------

	localparam rgb_t panel_color  = 12'h00f;
	localparam rgb_t digit_color  = 12'h009;
	localparam rgb_t border_color = 12'h049;
	localparam rgb_t blank_color  = 12'h000;

	// builds one frame entry for the layout tables
	function automatic frame_t make_frame(
		input int x_left,
		input int x_right,
		input int y_top,
		input int y_bottom,
		input int thickness
	);
		frame_t f;
		f.x_left    = coord_t'(x_left);
		f.x_right   = coord_t'(x_right);
		f.y_top     = coord_t'(y_top);
		f.y_bottom  = coord_t'(y_bottom);
		f.thickness = thick_t'(thickness);
		return f;
	endfunction

endpackage

`default_nettype wire

//--- logic/frame_layout.svh
// on-screen layout of the clock display overlay
// expects frame_overlay_pkg to be imported by the including scope

localparam int panel_count  = 3;
localparam int digit_count  = 9;
localparam int border_count = 3;

// --------------------
// panels
// --------------------

// time, date and stopwatch boxes
localparam frame_t [0:panel_count-1] panel_frames = '{
	make_frame(169, 534,  40, 150, 5),
	make_frame(140, 568, 175, 275, 5),
	make_frame(169, 534, 298, 410, 5)
};

// --------------------
// digits
// --------------------

// three boxes per panel, left to right
localparam frame_t [0:digit_count-1] digit_frames = '{
	// time row
	make_frame(179, 268,  54, 137, 4),
	make_frame(307, 396,  54, 137, 4),
	make_frame(435, 524,  54, 137, 4),
	// date row
	make_frame(150, 235, 182, 265, 4),
	make_frame(307, 392, 182, 265, 4),
	make_frame(469, 555, 182, 265, 4),
	// stopwatch row
	make_frame(179, 268, 310, 393, 4),
	make_frame(307, 396, 310, 393, 4),
	make_frame(435, 524, 310, 393, 4)
};

// --------------------
// borders
// --------------------

// thin outer boxes around each panel
localparam frame_t [0:border_count-1] border_frames = '{
	make_frame(28, 550,  30, 157, 3),
	make_frame(28, 580, 165, 285, 3),
	make_frame(28, 547, 290, 420, 3)
};
